// File: src/stream_pkg.sv
// Stream scale-and-offset package
// Sample, coefficient and result types shared by the datapath
// Fixed-point format constants and clamp limits
package stream_pkg;

   // Sample width in bits
   localparam int SAMPLE_W = 16;

   // Fraction bits of the Q8.8 gain
   localparam int FRAC_W = 8;

   // Signed input sample
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // Signed gain, 8 integer bits and 8 fraction bits
   typedef logic signed [SAMPLE_W-1:0] gain_t;

   // Signed offset, added after the gain is applied
   typedef logic signed [SAMPLE_W-1:0] offset_t;

   // Full-precision product of sample and gain
   typedef logic signed [2*SAMPLE_W-1:0] prod_t;

   // Output word
   // value holds the clamped sum
   // sat is set when the clamp changed the sum
   typedef struct packed {
      sample_t value;
      logic    sat;
   } result_t;

   // Clamp limits of the signed 16-bit range
   localparam sample_t SAMPLE_MAX = 16'sh7fff;
   localparam sample_t SAMPLE_MIN = 16'sh8000;

endpackage

// File: src/pipestage.sv
// Valid/ready pipestage
// Two-entry circular buffer with head and tail pointers
// Registers both the forward and the backward path, one cycle latency
// BYPASS turns the stage into a zero-latency pass-through
`timescale 1ns/100ps

module pipestage #(
   parameter int  BYPASS    = 0,
   parameter type payload_t = logic [63:0]
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   generate
      if (BYPASS == 0) begin : g_buffer
         // Entry storage, payload only
         payload_t data0;
         payload_t data1;
         // Per-entry occupancy
         logic     valid0;
         logic     valid1;
         // Single-bit pointers, head is the next free slot
         logic     head;
         logic     tail;
         // Handshake completions on each side
         logic     in_accept;
         logic     out_accept;

         // Item enters when the source offers and a slot is free
         assign in_accept  = in_valid & in_ready;
         // Item leaves when the sink takes the oldest entry
         assign out_accept = out_valid & out_ready;

         // Ready only depends on local state, so no combinational path upstream
         assign in_ready  = ~(valid0 & valid1);
         // Either entry holding data is enough to present
         assign out_valid = valid0 | valid1;

         // Oldest entry sits under tail
         assign out_data = tail ? data1 : data0;

         // Payload registers
         // Written into the slot under head on an input transfer
         always_ff @(posedge clk) begin
            if (in_accept && !head) begin
               data0 <= in_data;
            end
            if (in_accept && head) begin
               data1 <= in_data;
            end
         end

         // Valid bits and pointers
         always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
               valid0 <= 1'b0;
               valid1 <= 1'b0;
               head   <= 1'b0;
               tail   <= 1'b0;
            end else begin
               // Clear the entry being read
               if (out_accept && !tail) begin
                  valid0 <= 1'b0;
               end
               if (out_accept && tail) begin
                  valid1 <= 1'b0;
               end
               // Set the entry being written
               // head never points at an occupied slot while in_ready is high
               if (in_accept && !head) begin
                  valid0 <= 1'b1;
               end
               if (in_accept && head) begin
                  valid1 <= 1'b1;
               end
               // Advance pointers on their own side's transfer
               if (in_accept) begin
                  head <= ~head;
               end
               if (out_accept) begin
                  tail <= ~tail;
               end
            end
         end
      end else begin : g_bypass
         // Straight pass-through, zero latency
         assign out_valid = in_valid;
         assign in_ready  = out_ready;
         assign out_data  = in_data;
      end
   endgenerate

endmodule

// File: src/scale_unit.sv
// Scale-and-offset unit
// Stage one forms sample x gain, stage two shifts, adds offset and clamps
// Both stages share one advance enable and stall together
// sat marks any result pushed to the 16-bit limits
`timescale 1ns/100ps

module scale_unit
   import stream_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   input  gain_t   gain,
   input  offset_t offset,
   input  logic    in_valid,
   output logic    in_ready,
   input  sample_t in_data,
   output logic    out_valid,
   input  logic    out_ready,
   output result_t out_data
);

   // Width of the scaled value plus offset
   // product after the shift keeps 24 bits, one more covers the add
   localparam int SUM_W = 2*SAMPLE_W - FRAC_W + 1;

   // Clamp limits widened to the sum width
   localparam logic signed [SUM_W-1:0] SUM_MAX = SUM_W'(SAMPLE_MAX);
   localparam logic signed [SUM_W-1:0] SUM_MIN = SUM_W'(SAMPLE_MIN);

   // Stage one state
   prod_t   prod_q;
   logic    v1_q;

   // Stage two state
   result_t res_q;
   logic    v2_q;

   // Global enable for both stages
   logic    advance;

   // Stage two combinational result
   logic signed [SUM_W-1:0] scaled;
   logic signed [SUM_W-1:0] offset_ext;
   logic signed [SUM_W-1:0] sum;
   result_t                 res_d;

   // Pipeline moves when the last stage is empty or being drained
   assign advance  = ~v2_q | out_ready;
   // Accept input exactly when stage one will be loaded
   assign in_ready = advance;

   assign out_valid = v2_q;
   assign out_data  = res_q;

   // Arithmetic shift right by FRAC_W with explicit sign extension
   // floor rounding falls out of dropping the low product bits
   assign scaled = {prod_q[2*SAMPLE_W-1], prod_q[2*SAMPLE_W-1:FRAC_W]};

   // Offset sign-extended to the sum width
   assign offset_ext = {{(SUM_W-SAMPLE_W){offset[SAMPLE_W-1]}}, offset};

   assign sum = scaled + offset_ext;

   // Clamp to the signed 16-bit range
   always_comb begin
      if (sum > SUM_MAX) begin
         res_d.value = SAMPLE_MAX;
         res_d.sat   = 1'b1;
      end else if (sum < SUM_MIN) begin
         res_d.value = SAMPLE_MIN;
         res_d.sat   = 1'b1;
      end else begin
         // In range, low bits carry the exact value
         res_d.value = sum[SAMPLE_W-1:0];
         res_d.sat   = 1'b0;
      end
   end

   // Stage valid bits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         v1_q <= 1'b0;
         v2_q <= 1'b0;
      end else if (advance) begin
         v1_q <= in_valid;
         v2_q <= v1_q;
      end
   end

   // Stage payload registers
   // held under stall, loaded only behind a valid bit
   always_ff @(posedge clk) begin
      if (advance && in_valid) begin
         // 16 x 16 signed multiply, full 32-bit product
         prod_q <= in_data * gain;
      end
      if (advance && v1_q) begin
         res_q <= res_d;
      end
   end

endmodule

// File: src/scale_pipe_top.sv
// Scale pipe top level
// Input pipestage, scale-and-offset unit and output pipestage in series
// Every link is a valid/ready handshake
// gain and offset are static, changed only while the pipe is empty
`timescale 1ns/100ps

module scale_pipe_top
   import stream_pkg::*;
#(
   parameter int IN_BYPASS  = 0,
   parameter int OUT_BYPASS = 0
) (
   input  logic    clk,
   input  logic    arst_n,
   input  gain_t   gain,
   input  offset_t offset,
   input  logic    in_valid,
   output logic    in_ready,
   input  sample_t in_data,
   output logic    out_valid,
   input  logic    out_ready,
   output result_t out_data
);

   // Input stage to scale unit
   logic    s_valid;
   logic    s_ready;
   sample_t s_data;

   // Scale unit to output stage
   logic    r_valid;
   logic    r_ready;
   result_t r_data;

   // Registers incoming samples
   pipestage #(
      .BYPASS    (IN_BYPASS),
      .payload_t (sample_t)
   ) u_in_stage (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (s_valid),
      .out_ready (s_ready),
      .out_data  (s_data)
   );

   // Two-cycle multiply, offset and clamp
   scale_unit u_scale (
      .clk       (clk),
      .arst_n    (arst_n),
      .gain      (gain),
      .offset    (offset),
      .in_valid  (s_valid),
      .in_ready  (s_ready),
      .in_data   (s_data),
      .out_valid (r_valid),
      .out_ready (r_ready),
      .out_data  (r_data)
   );

   // Registers results, decouples the external ready from the scale stall
   pipestage #(
      .BYPASS    (OUT_BYPASS),
      .payload_t (result_t)
   ) u_out_stage (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (r_valid),
      .in_ready  (r_ready),
      .in_data   (r_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

endmodule

// File: verification/scale_pipe_assert.sv
// Handshake checks for the scale pipe top level
// Hold and stability rules on both valid/ready ports
// Output stays quiet while reset is asserted
`timescale 1ns/100ps

module scale_pipe_assert
   import stream_pkg::*;
(
   input logic    clk,
   input logic    arst_n,
   input logic    in_valid,
   input logic    in_ready,
   input sample_t in_data,
   input logic    out_valid,
   input logic    out_ready,
   input result_t out_data
);

   // Failed checks so far
   int fail_count = 0;

   // Offered result may not be withdrawn
   a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid)
   else begin
      fail_count++;
      $error("out_valid dropped before out_ready");
   end

   // Offered result may not change
   a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> $stable(out_data))
   else begin
      fail_count++;
      $error("out_data changed while waiting for out_ready");
   end

   // Source side holds its offer the same way
   a_in_hold: assert property (@(posedge clk) disable iff (!arst_n)
      in_valid && !in_ready |=> in_valid && $stable(in_data))
   else begin
      fail_count++;
      $error("in_valid or in_data changed before in_ready");
   end

   a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
   else begin
      fail_count++;
      $error("out_valid high during reset");
   end

endmodule

bind scale_pipe_top scale_pipe_assert u_assert (
   .clk       (clk),
   .arst_n    (arst_n),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .in_data   (in_data),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_data  (out_data)
);

// File: verification/scale_pipe_tb.sv
// Scale pipe testbench
// Directed tests of the scale-and-offset stream against a floor and clamp model
// Output scoreboard, LCG stimulus and a watchdog
`timescale 1ns/100ps

module scale_pipe_tb
   import stream_pkg::*;
();

   localparam int CLK_NS    = 10;
   localparam int RESET_CYC = 16;
   localparam int STREAM_N  = 32;
   localparam int BP_N      = 64;
   // Items held by the blocked pipe, two per stage
   localparam int PIPE_DEPTH = 6;
   // Fill items plus the one left waiting at the input
   localparam int FILL_N     = PIPE_DEPTH + 1;
   localparam int SAT_N      = 10;
   localparam int TOTAL_N    = 1 + STREAM_N + BP_N + FILL_N + SAT_N;
   localparam int WATCHDOG_NS = (RESET_CYC + 8 * TOTAL_N + 200) * CLK_NS;
   // Input transfer edge to the edge that sees out_valid
   localparam int SINGLE_LAT = 4;
   // Gain of 1.0 in Q8.8
   localparam gain_t UNITY = 16'sh0100;

   logic    clk;
   logic    arst_n;
   gain_t   gain;
   offset_t offset;
   logic    in_valid;
   logic    in_ready;
   sample_t in_data;
   logic    out_valid;
   logic    out_ready;
   result_t out_data;

   // Scoreboard
   result_t     exp_q[$];
   result_t     mon_exp;
   int          received = 0;
   string       test_name;
   // Stimulus state
   logic [31:0] lcg_state;
   logic        rand_ready;

   scale_pipe_top #(
      .IN_BYPASS  (0),
      .OUT_BYPASS (0)
   ) u_scale_pipe_top (
      .clk       (clk),
      .arst_n    (arst_n),
      .gain      (gain),
      .offset    (offset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

   always #(CLK_NS / 2) clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // floor(s * g / 256) + o, clamped to the signed 16-bit range
   function automatic result_t scale_model(sample_t s, gain_t g, offset_t o);
      longint  prod;
      longint  sum;
      result_t r;
      prod = longint'(s) * longint'(g);
      // Arithmetic shift of a signed value rounds toward minus infinity
      sum = (prod >>> FRAC_W) + longint'(o);
      if (sum > 32767) begin
         r.value = 16'sh7fff;
         r.sat   = 1'b1;
      end else if (sum < -32768) begin
         r.value = 16'sh8000;
         r.sat   = 1'b1;
      end else begin
         r.value = sample_t'(sum);
         r.sat   = 1'b0;
      end
      return r;
   endfunction

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_result(input string name, input result_t exp, input result_t act);
      if (act !== exp) begin
         fail_run($sformatf("[FAIL] %s expected value=%0d sat=%0b actual value=%0d sat=%0b",
                            name, exp.value, exp.sat, act.value, act.sat));
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         fail_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
      end
   endtask

   // One clock, then drive 1 ns after the edge
   task automatic next_cycle();
      logic [31:0] r;
      @(posedge clk);
      #1;
      if (rand_ready) begin
         r = lcg_next();
         out_ready = r[29];
      end
   endtask

   // Offer one sample and hold it until the input stage takes it
   task automatic send_sample(input sample_t s, input result_t exp);
      logic ready_seen;
      in_data  = s;
      in_valid = 1'b1;
      exp_q.push_back(exp);
      ready_seen = 1'b0;
      while (!ready_seen) begin
         ready_seen = in_ready;
         next_cycle();
      end
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         next_cycle();
      end
   endtask

   // Coefficients change only with the pipe empty
   task automatic send_fixed(input sample_t s, input gain_t g, input offset_t o,
                             input sample_t value, input logic sat);
      result_t exp;
      wait_drain();
      gain      = g;
      offset    = o;
      exp.value = value;
      exp.sat   = sat;
      send_sample(s, exp);
   endtask

   // Transfer seen at the negedge completes at the next rising edge
   always @(negedge clk) begin
      if (u_scale_pipe_top.u_assert.fail_count != 0) begin
         fail_run("A handshake assertion on the top level failed");
      end else if (arst_n && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            fail_run("Output handshake with no sample outstanding");
         end else begin
            mon_exp = exp_q.pop_front();
            check_result(test_name, mon_exp, out_data);
            received = received + 1;
         end
      end
   end

   task automatic test_reset();
      test_name = "test_reset";
      check_bit("test_reset out_valid", 1'b0, out_valid);
      check_bit("test_reset in_ready", 1'b1, in_ready);
   endtask

   task automatic test_single();
      int      cycles;
      result_t exp;
      test_name = "test_single";
      gain      = UNITY;
      offset    = 16'sd0;
      out_ready = 1'b1;
      exp.value = 16'sh1234;
      exp.sat   = 1'b0;
      send_sample(16'sh1234, exp);
      // Value seen now is the one the next edge samples
      cycles = 1;
      while (!out_valid) begin
         next_cycle();
         cycles++;
      end
      check_count("test_single latency", SINGLE_LAT, cycles);
      wait_drain();
   endtask

   task automatic test_stream();
      logic [31:0] r;
      sample_t     s;
      int          start;
      test_name = "test_stream";
      start     = received;
      out_ready = 1'b1;
      // Gain within about +-2.0 and any offset
      r      = lcg_next();
      gain   = gain_t'({{6{r[9]}}, r[9:0]});
      offset = offset_t'(r[31:16]);
      for (int i = 0; i < STREAM_N; i++) begin
         r = lcg_next();
         s = sample_t'(r[31:16]);
         send_sample(s, scale_model(s, gain, offset));
      end
      wait_drain();
      check_count("test_stream count", STREAM_N, received - start);
   endtask

   task automatic test_backpressure();
      logic [31:0] r;
      sample_t     s;
      int          start;
      int          accepts;
      logic        ready_seen;
      test_name = "test_backpressure";
      start     = received;
      r      = lcg_next();
      gain   = gain_t'({{6{r[9]}}, r[9:0]});
      offset = offset_t'(r[31:16]);
      rand_ready = 1'b1;
      for (int i = 0; i < BP_N; i++) begin
         r = lcg_next();
         s = sample_t'(r[31:16]);
         send_sample(s, scale_model(s, gain, offset));
      end
      wait_drain();
      rand_ready = 1'b0;
      check_count("test_backpressure count", BP_N, received - start);
      // Block the output and push until every stage is full
      out_ready = 1'b0;
      accepts   = 0;
      r         = lcg_next();
      in_data   = sample_t'(r[31:16]);
      in_valid  = 1'b1;
      for (int i = 0; i < 2 * PIPE_DEPTH + 4; i++) begin
         ready_seen = in_ready;
         next_cycle();
         if (ready_seen) begin
            accepts++;
            exp_q.push_back(scale_model(in_data, gain, offset));
            r       = lcg_next();
            in_data = sample_t'(r[31:16]);
         end
      end
      check_count("test_backpressure accepts", PIPE_DEPTH, accepts);
      check_bit("test_backpressure in_ready", 1'b0, in_ready);
      // Held sample goes in once the output drains
      out_ready = 1'b1;
      send_sample(in_data, scale_model(in_data, gain, offset));
      wait_drain();
      check_count("test_backpressure total", BP_N + FILL_N, received - start);
   endtask

   task automatic test_saturate();
      int start;
      test_name = "test_saturate";
      start     = received;
      out_ready = 1'b1;
      // Clamped by a large gain or offset
      send_fixed(16'sh7fff, 16'sh7fff, 16'sd0, 16'sh7fff, 1'b1);
      send_fixed(16'sh8000, 16'sh7fff, 16'sd0, 16'sh8000, 1'b1);
      // Large negative gain flips the sign before the clamp
      send_fixed(16'sh7fff, 16'sh8000, 16'sd0, 16'sh8000, 1'b1);
      send_fixed(16'sh8000, 16'sh8000, 16'sd0, 16'sh7fff, 1'b1);
      send_fixed(16'sd100, UNITY, 16'sh7fff, 16'sh7fff, 1'b1);
      send_fixed(-16'sd100, UNITY, 16'sh8000, 16'sh8000, 1'b1);
      // Right at the limits, no clamp
      send_fixed(16'sh7fff, UNITY, 16'sd0, 16'sh7fff, 1'b0);
      send_fixed(16'sh8000, UNITY, 16'sd0, 16'sh8000, 1'b0);
      send_fixed(-16'sd1, UNITY, 16'sh7fff, 16'sd32766, 1'b0);
      // -0.5 floors to -1, lands exactly on the low limit
      send_fixed(-16'sd1, 16'sh0080, 16'sh8001, 16'sh8000, 1'b0);
      wait_drain();
      check_count("test_saturate count", SAT_N, received - start);
   endtask

   initial begin
      clk        = 1'b0;
      arst_n     = 1'b0;
      gain       = UNITY;
      offset     = 16'sd0;
      in_valid   = 1'b0;
      in_data    = '0;
      out_ready  = 1'b1;
      lcg_state  = 32'hd0c1;
      rand_ready = 1'b0;
      test_name  = "reset";
      repeat (RESET_CYC) @(posedge clk);
      #1;
      arst_n = 1'b1;
      test_reset();
      test_single();
      test_stream();
      test_backpressure();
      test_saturate();
      if (exp_q.size() == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         fail_run("Expected results still outstanding at the end of the run");
      end
   end

   // Budget of a few cycles per item on top of reset
   initial begin
      #(WATCHDOG_NS);
      fail_run($sformatf("Timeout after %0d ns, the pipeline stopped responding", WATCHDOG_NS));
   end

endmodule

// File: tb.f
src/stream_pkg.sv
src/pipestage.sv
src/scale_unit.sv
src/scale_pipe_top.sv
verification/scale_pipe_assert.sv
verification/scale_pipe_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the scale pipe testbench with Verilator
# Exit status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module scale_pipe_tb -f tb.f -o scale_pipe_sim \
   && ./obj_dir/scale_pipe_sim | tee /dev/stderr | grep -qF '>>> PASS' \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
